//--- src/vga_params.svh
// VGA display timing and bus sizes

`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// ------------------------------
// horizontal timing in clocks
// ------------------------------
`define H_DISPLAY      16
`define H_FRONT_PORCH  2
`define H_SYNC_PULSE   3
`define H_BACK_PORCH   3
`define H_COUNT        (`H_DISPLAY + `H_FRONT_PORCH + `H_SYNC_PULSE + `H_BACK_PORCH)

// ------------------------------
// vertical timing in lines
// ------------------------------
`define V_DISPLAY      8
`define V_FRONT_PORCH  1
`define V_SYNC_PULSE   2
`define V_BACK_PORCH   1
`define V_COUNT        (`V_DISPLAY + `V_FRONT_PORCH + `V_SYNC_PULSE + `V_BACK_PORCH)

// counter widths
`define H_SIZE         5
`define V_SIZE         4

// frame buffer, H_DISPLAY must stay a power of two
`define FB_AW          7

// wishbone slave
`define WB_AW          8
`define WB_DW          16
`define CTRL_ADDR      128

// counter, memory and pin registers
`define SCAN_LATENCY   3

`endif

//--- src/vga_pkg.sv
// VGA shared types

`default_nettype none

`include "vga_params.svh"

package vga_pkg;

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // pixel index, row and column side by side
    typedef logic [`FB_AW-1:0] fb_addr_t;

    // control bits carried along the scan pipeline
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic video_on;
    } sync_t;

endpackage

`default_nettype wire

//--- src/vga_timing_gen.sv
// VGA raster timing generator

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_timing_gen (
    input  wire                    pixel_clk,
    input  wire                    arst_n,
    input  wire                    enable,
    output vga_pkg::fb_addr_t      scan_addr,
    output vga_pkg::sync_t         scan_sync
);

    import vga_pkg::*;

    // column bits of the pixel address, the rest is the row
    localparam int HA_W = $clog2(`H_DISPLAY);
    localparam int VA_W = `FB_AW - HA_W;

    logic [`H_SIZE-1:0] h;
    logic [`V_SIZE-1:0] v;
    logic               h_last;
    logic               v_last;
    logic               h_sync_on;
    logic               v_sync_on;
    logic               visible;

    // ------------------------------
    // raster counters
    // ------------------------------
    assign h_last = (h == `H_COUNT - 1);
    assign v_last = (v == `V_COUNT - 1);

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            h <= '0;
            v <= '0;
        end else if (!enable) begin
            // parked at the top left corner
            h <= '0;
            v <= '0;
        end else begin
            if (h_last) begin
                h <= '0;
                v <= v_last ? '0 : v + 1'b1;
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    // ------------------------------
    // decode
    // ------------------------------
    // line order is display, front porch, sync, back porch
    assign h_sync_on = (h >= `H_DISPLAY + `H_FRONT_PORCH) &&
                       (h <  `H_DISPLAY + `H_FRONT_PORCH + `H_SYNC_PULSE);
    assign v_sync_on = (v >= `V_DISPLAY + `V_FRONT_PORCH) &&
                       (v <  `V_DISPLAY + `V_FRONT_PORCH + `V_SYNC_PULSE);
    assign visible   = (h < `H_DISPLAY) && (v < `V_DISPLAY);

    assign scan_addr = fb_addr_t'({v[VA_W-1:0], h[HA_W-1:0]});

    // syncs are active low, everything idle while disabled
    always_comb begin
        scan_sync.hsync    = !(enable && h_sync_on);
        scan_sync.vsync    = !(enable && v_sync_on);
        scan_sync.video_on = enable && visible;
    end

endmodule

`default_nettype wire

//--- src/wb_frame_buffer.sv
// Frame buffer with Wishbone slave port

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module wb_frame_buffer (
    input  wire                    pixel_clk,
    input  wire                    arst_n,
    // wishbone classic slave
    input  wire                    cyc,
    input  wire                    stb,
    input  wire                    we,
    input  wire  [`WB_AW-1:0]      adr,
    input  wire  [`WB_DW-1:0]      dat_w,
    output logic [`WB_DW-1:0]      dat_r,
    output logic                   ack,
    // control
    output logic                   enable,
    // scan read port
    input  vga_pkg::fb_addr_t      scan_addr,
    output vga_pkg::rgb_t          scan_rgb
);

    import vga_pkg::*;

    localparam int FB_DEPTH = 1 << `FB_AW;
    localparam int RGB_W    = $bits(rgb_t);

    rgb_t               mem [FB_DEPTH];
    logic               bus_req;
    logic               pix_sel;
    logic               ctrl_sel;
    fb_addr_t           bus_addr;
    logic [`WB_DW-1:0]  rd_word;

    // ------------------------------
    // bus decode
    // ------------------------------
    // new request only while ack is low, so ack pulses every other cycle
    assign bus_req  = cyc && stb && !ack;
    assign pix_sel  = (adr[`WB_AW-1:`FB_AW] == '0);
    assign ctrl_sel = (adr == `CTRL_ADDR);
    assign bus_addr = adr[`FB_AW-1:0];

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= bus_req;
        end
    end

    // scan enable lives in bit 0
    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            enable <= 1'b0;
        end else if (bus_req && we && ctrl_sel) begin
            enable <= dat_w[0];
        end
    end

    // ------------------------------
    // read mux
    // ------------------------------
    // unmapped addresses read as zero
    always_comb begin
        rd_word = '0;
        if (pix_sel) begin
            rd_word[RGB_W-1:0] = mem[bus_addr];
        end else if (ctrl_sel) begin
            rd_word[0] = enable;
        end
    end

    // ------------------------------
    // pixel memory
    // ------------------------------
    always_ff @(posedge pixel_clk) begin
        if (bus_req && we && pix_sel) begin
            mem[bus_addr] <= rgb_t'(dat_w[RGB_W-1:0]);
        end
        if (bus_req) begin
            dat_r <= rd_word;
        end
        // second port, one cycle read for the scan pipeline
        scan_rgb <= mem[scan_addr];
    end

endmodule

`default_nettype wire

//--- src/vga_stage_delay.sv
// Pipeline delay stage for any payload

`timescale 1ns/1ps
`default_nettype none

module vga_stage_delay #(
    parameter type      payload_t = logic,
    parameter int       DEPTH     = 1,
    // value held out of reset
    parameter payload_t IDLE      = '0
) (
    input  wire         pixel_clk,
    input  wire         arst_n,
    input  payload_t    in_data,
    output payload_t    out_data
);

    payload_t pipe [DEPTH];

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= IDLE;
            end
        end else begin
            pipe[0] <= in_data;
            // shift towards the output
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign out_data = pipe[DEPTH-1];

endmodule

`default_nettype wire

//--- src/vga_output_stage.sv
// VGA pin registers with blanking

`timescale 1ns/1ps
`default_nettype none

module vga_output_stage (
    input  wire                 pixel_clk,
    input  wire                 arst_n,
    input  vga_pkg::rgb_t       rgb,
    input  vga_pkg::sync_t      sync,
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                vga_hsync,
    output logic                vga_vsync
);

    import vga_pkg::*;

    rgb_t pix;

    // black outside the visible area
    assign pix = sync.video_on ? rgb : '0;

    always_ff @(posedge pixel_clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else begin
            vga_r     <= pix.r;
            vga_g     <= pix.g;
            vga_b     <= pix.b;
            vga_hsync <= sync.hsync;
            vga_vsync <= sync.vsync;
        end
    end

endmodule

`default_nettype wire

//--- src/vga_core.sv
// VGA core with on-chip frame buffer

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module vga_core (
    input  wire                  pixel_clk,
    input  wire                  arst_n,
    // wishbone classic slave
    input  wire                  cyc,
    input  wire                  stb,
    input  wire                  we,
    input  wire  [`WB_AW-1:0]    adr,
    input  wire  [`WB_DW-1:0]    dat_w,
    output wire  [`WB_DW-1:0]    dat_r,
    output wire                  ack,
    // vga pins
    output wire  [3:0]           vga_r,
    output wire  [3:0]           vga_g,
    output wire  [3:0]           vga_b,
    output wire                  vga_hsync,
    output wire                  vga_vsync
);

    import vga_pkg::*;

    // syncs inactive and no video
    localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, video_on: 1'b0};

    logic       enable;
    fb_addr_t   scan_addr;
    sync_t      scan_sync;
    sync_t      sync_d;
    rgb_t       scan_rgb;

    // ------------------------------
    // scan pipeline
    // ------------------------------
    vga_timing_gen u_timing (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .enable    (enable),
        .scan_addr (scan_addr),
        .scan_sync (scan_sync)
    );

    wb_frame_buffer u_fb (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .enable    (enable),
        .scan_addr (scan_addr),
        .scan_rgb  (scan_rgb)
    );

    // match the memory read, counter and pin stages make up the rest
    vga_stage_delay #(
        .payload_t (sync_t),
        .DEPTH     (`SCAN_LATENCY - 2),
        .IDLE      (SYNC_IDLE)
    ) u_sync_delay (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .in_data   (scan_sync),
        .out_data  (sync_d)
    );

    vga_output_stage u_out (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .rgb       (scan_rgb),
        .sync      (sync_d),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

endmodule

`default_nettype wire

//--- tests/tb_vga_core.sv
// Testbench for the VGA core

`timescale 1ns/1ps
`default_nettype none

`include "vga_params.svh"

module tb_vga_core;

    import vga_pkg::*;

    localparam int FB_DEPTH  = 1 << `FB_AW;
    localparam int ACK_LIMIT = 16;
    localparam int PIN_LIMIT = `H_COUNT * `V_COUNT + 8;

    logic              pixel_clk;
    logic              arst_n;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`WB_AW-1:0] adr;
    logic [`WB_DW-1:0] dat_w;
    wire  [`WB_DW-1:0] dat_r;
    wire               ack;
    wire  [3:0]        vga_r;
    wire  [3:0]        vga_g;
    wire  [3:0]        vga_b;
    wire               vga_hsync;
    wire               vga_vsync;

    rgb_t   model [FB_DEPTH];
    integer seed     = 32'hd8d8_78e7;
    int     errors   = 0;
    int     timeouts = 0;
    int     waited   = 0;
    bit     lost     = 1'b0;

    vga_core dut (
        .pixel_clk (pixel_clk),
        .arst_n    (arst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

    always #2 pixel_clk = ~pixel_clk;

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %03h expected %03h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [`WB_DW-1:0] got, input logic [`WB_DW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    // hsync in bit 1, vsync in bit 0
    task automatic check_sync(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic rgb_t pin_rgb();
        return rgb_t'({vga_r, vga_g, vga_b});
    endfunction

    // ------------------------------
    // bus model
    // ------------------------------
    task automatic bus_access(input logic write, input logic [`WB_AW-1:0] addr,
                              input logic [`WB_DW-1:0] data, output logic [`WB_DW-1:0] rdata);
        int n;
        rdata = '0;
        @(posedge pixel_clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= data;
        for (n = 0; n < ACK_LIMIT; n++) begin
            @(negedge pixel_clk);
            if (ack) break;
        end
        if (n == ACK_LIMIT) begin
            timeouts++;
            $display("timeout: no ack for the bus access at address %0d", addr);
        end else begin
            rdata = dat_r;
            check_word(16'(n), 16'd1, "clocks from strobe to ack");
        end
        @(posedge pixel_clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        // stb was still high at that edge
        @(negedge pixel_clk);
        check_word({{(`WB_DW-1){1'b0}}, ack}, '0, "ack longer than one cycle");
    endtask

    task automatic wb_write(input logic [`WB_AW-1:0] addr, input logic [`WB_DW-1:0] data);
        logic [`WB_DW-1:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [`WB_AW-1:0] addr, output logic [`WB_DW-1:0] data);
        bus_access(1'b0, addr, '0, data);
    endtask

    // ------------------------------
    // pin watching
    // ------------------------------
    // waited ends up as the clock count until the level showed
    task automatic wait_pin(input bit vert, input logic level, input bit blank);
        logic pin;
        waited = 0;
        if (lost) return;
        for (waited = 1; waited <= PIN_LIMIT; waited++) begin
            @(negedge pixel_clk);
            pin = vert ? vga_vsync : vga_hsync;
            if (pin === level) break;
            if (blank) check_rgb(pin_rgb(), '0, "colour outside the visible area");
        end
        if (waited > PIN_LIMIT) begin
            lost = 1'b1;
            timeouts++;
            $display("timeout: %s never went to %b", vert ? "vsync" : "hsync", level);
        end
    endtask

    task automatic idle_pins(input int clocks, input string tag);
        repeat (clocks) begin
            @(negedge pixel_clk);
            check_word({{(`WB_DW-1){1'b0}}, ack}, '0, {tag, " ack"});
            check_sync({vga_hsync, vga_vsync}, 2'b11, {tag, " syncs"});
            check_rgb(pin_rgb(), '0, {tag, " colour"});
        end
    endtask

    task automatic frame_compare(input string tag);
        int row;
        int x;
        wait_pin(1'b1, 1'b0, 1'b0);
        wait_pin(1'b1, 1'b1, 1'b1);
        repeat (`V_BACK_PORCH - 1) begin
            wait_pin(1'b0, 1'b0, 1'b1);
            wait_pin(1'b0, 1'b1, 1'b1);
        end
        for (row = 0; row < `V_DISPLAY; row++) begin
            wait_pin(1'b0, 1'b0, 1'b1);
            wait_pin(1'b0, 1'b1, 1'b1);
            if (lost) return;
            repeat (`H_BACK_PORCH - 1) begin
                @(negedge pixel_clk);
                check_rgb(pin_rgb(), '0, "back porch colour");
            end
            for (x = 0; x < `H_DISPLAY; x++) begin
                @(negedge pixel_clk);
                check_rgb(pin_rgb(), model[row * `H_DISPLAY + x],
                          $sformatf("%s pixel x %0d y %0d", tag, x, row));
            end
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic reset_state();
        logic [`WB_DW-1:0] rdata;
        idle_pins(100, "after reset");
        wb_read(`CTRL_ADDR, rdata);
        check_word(rdata, '0, "control after reset");
    endtask

    task automatic bus_loopback();
        logic [`WB_DW-1:0] data;
        logic [`WB_DW-1:0] rdata;
        int a;
        for (a = 0; a < FB_DEPTH; a++) begin
            data = 16'($random(seed));
            model[a] = rgb_t'(data[11:0]);
            wb_write(8'(a), data);
        end
        repeat (8) begin
            a = $random(seed) & (FB_DEPTH - 1);
            wb_read(8'(a), rdata);
            check_word(rdata, {4'b0, model[a]}, $sformatf("readback of pixel %0d", a));
        end
        wb_read(8'd200, rdata);
        check_word(rdata, '0, "unmapped address");
    endtask

    task automatic raster_content();
        logic [`WB_DW-1:0] rdata;
        wb_write(`CTRL_ADDR, 16'h0001);
        wb_read(`CTRL_ADDR, rdata);
        check_word(rdata, 16'h0001, "control after enable");
        frame_compare("first frame");
    endtask

    task automatic sync_shape();
        int low;
        wait_pin(1'b0, 1'b1, 1'b0);
        wait_pin(1'b0, 1'b0, 1'b0);
        wait_pin(1'b0, 1'b1, 1'b0);
        low = waited;
        wait_pin(1'b0, 1'b0, 1'b0);
        if (lost) return;
        check_word(16'(low), 16'(`H_SYNC_PULSE), "hsync low clocks");
        check_word(16'(low + waited), 16'(`H_COUNT), "clocks per line");
        wait_pin(1'b1, 1'b1, 1'b0);
        wait_pin(1'b1, 1'b0, 1'b0);
        wait_pin(1'b1, 1'b1, 1'b0);
        if (lost) return;
        check_word(16'(waited), 16'(`V_SYNC_PULSE * `H_COUNT), "vsync low clocks");
    endtask

    task automatic live_update();
        logic [`WB_DW-1:0] data;
        data = 16'($random(seed));
        model[0] = rgb_t'(data[11:0]);
        wb_write(8'd0, data);
        data = 16'($random(seed));
        model[FB_DEPTH-1] = rgb_t'(data[11:0]);
        wb_write(8'(FB_DEPTH - 1), data);
        frame_compare("updated frame");
    endtask

    task automatic disable_scan();
        logic [`WB_DW-1:0] rdata;
        wb_write(`CTRL_ADDR, 16'h0000);
        // pins are idle by the third clock after ack
        idle_pins(100, "after disable");
        wb_read(`CTRL_ADDR, rdata);
        check_word(rdata, '0, "control after disable");
    endtask

    initial begin
        pixel_clk = 1'b0;
        arst_n    = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        repeat (8) @(posedge pixel_clk);
        arst_n <= 1'b1;

        reset_state();
        bus_loopback();
        raster_content();
        sync_shape();
        live_update();
        disable_scan();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/vga_pkg.sv
src/vga_timing_gen.sv
src/wb_frame_buffer.sv
src/vga_stage_delay.sv
src/vga_output_stage.sv
src/vga_core.sv
tests/tb_vga_core.sv

//--- Makefile
SIM      = verilator
TOP      = tb_vga_core
FILELIST = tb.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
